/* Makefile */
TOP := bus_fabric_tb

.PHONY: all build lint clean

all: build
	./obj_dir/V$(TOP) +verilator+error+limit+100

build:
	verilator --binary --timing --assert --top-module $(TOP) -f bus_fabric.f

lint:
	verilator --lint-only --timing --top-module bus_fabric -f bus_fabric.f

clean:
	rm -rf obj_dir

/* bus_fabric.f */
hdl/soc_pkg.sv
hdl/addr_decode.sv
hdl/ram.sv
hdl/mmio_core.sv
hdl/rdata_mux.sv
hdl/bus_fabric.sv
test/bus_fabric_asserts.sv
test/bus_fabric_tb.sv

/* hdl/addr_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module addr_decode #(
  parameter int NUM_CORES = 4
) (
  input  wire                                     valid,
  input  soc_pkg::word_t                          addr,
  input  soc_pkg::word_t                          wdata,
  input  wire [3:0]                               wstrb,
  input  wire                                     bus_ready,

  output logic                                    ram_cs,
  output logic [3:0]                              ram_we,
  output logic [soc_pkg::ram_words_log2-1:0]      ram_address,
  output logic [NUM_CORES-1:0]                    core_cs,
  output logic                                    core_we,
  output logic [soc_pkg::core_regs_log2-1:0]      core_address,
  output soc_pkg::word_t                          write_data,
  output logic                                    direct_ack
);

  //----------------------------------------
  // Shared fields for all responders
  //----------------------------------------
  assign ram_address  = addr[soc_pkg::ram_words_log2+1:2];
  assign core_address = addr[soc_pkg::core_regs_log2+1:2];
  assign core_we      = |wstrb;
  assign write_data   = wdata;

  //----------------------------------------
  // Area and core select
  //----------------------------------------
  always_comb begin : decode
    soc_pkg::area_t                         area;
    logic [soc_pkg::core_msb-soc_pkg::core_lsb:0] core_field;

    area       = soc_pkg::area_t'(addr[soc_pkg::area_msb:soc_pkg::area_lsb]);
    core_field = addr[soc_pkg::core_msb:soc_pkg::core_lsb];

    ram_cs     = 1'b0;
    ram_we     = 4'h0;
    core_cs    = '0;
    direct_ack = 1'b0;

    // Only a new transfer, not the cycle the bus acks it
    if (valid && !bus_ready) begin
      case (area)
        soc_pkg::area_ram: begin
          ram_cs = 1'b1;
          ram_we = wstrb;
        end

        soc_pkg::area_mmio: begin
          if (int'(core_field) < NUM_CORES) begin
            for (int i = 0; i < NUM_CORES; i++) begin
              core_cs[i] = (int'(core_field) == i);
            end
          end
          else begin
            // Absent core
            direct_ack = 1'b1;
          end
        end

        // Reserved codes 0 and 2
        default: begin
          direct_ack = 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/bus_fabric.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_fabric #(
  parameter int NUM_CORES = 4
) (
  input  wire              clk,
  input  wire              reset_n,

  input  wire              valid,
  input  soc_pkg::word_t   addr,
  input  soc_pkg::word_t   wdata,
  input  wire [3:0]        wstrb,
  output logic             ready,
  output soc_pkg::word_t   rdata
);

  //----------------------------------------
  // Decoder outputs
  //----------------------------------------
  logic                                   ram_cs;
  logic [3:0]                             ram_we;
  logic [soc_pkg::ram_words_log2-1:0]     ram_address;
  logic [NUM_CORES-1:0]                   core_cs;
  logic                                   core_we;
  logic [soc_pkg::core_regs_log2-1:0]     core_address;
  soc_pkg::word_t                         write_data;
  logic                                   direct_ack;

  // Responder outputs
  soc_pkg::word_t                         ram_read_data;
  logic                                   ram_ready;
  soc_pkg::word_t [NUM_CORES-1:0]         core_read_data;
  logic [NUM_CORES-1:0]                   core_ready;

  addr_decode #(
    .NUM_CORES(NUM_CORES)
  ) addr_decode_inst (
    .valid       (valid),
    .addr        (addr),
    .wdata       (wdata),
    .wstrb       (wstrb),
    .bus_ready   (ready),
    .ram_cs      (ram_cs),
    .ram_we      (ram_we),
    .ram_address (ram_address),
    .core_cs     (core_cs),
    .core_we     (core_we),
    .core_address(core_address),
    .write_data  (write_data),
    .direct_ack  (direct_ack)
  );

  ram ram_inst (
    .clk       (clk),
    .reset_n   (reset_n),
    .cs        (ram_cs),
    .we        (ram_we),
    .address   (ram_address),
    .write_data(write_data),
    .read_data (ram_read_data),
    .ready     (ram_ready)
  );

  //----------------------------------------
  // MMIO cores, one per select bit
  //----------------------------------------
  for (genvar i = 0; i < NUM_CORES; i++) begin : gen_core
    mmio_core #(
      .CORE_ID(i)
    ) core_inst (
      .clk       (clk),
      .reset_n   (reset_n),
      .cs        (core_cs[i]),
      .we        (core_we),
      .address   (core_address),
      .write_data(write_data),
      .read_data (core_read_data[i]),
      .ready     (core_ready[i])
    );
  end

  rdata_mux #(
    .NUM_CORES(NUM_CORES)
  ) rdata_mux_inst (
    .clk           (clk),
    .reset_n       (reset_n),
    .ram_cs        (ram_cs),
    .ram_ready     (ram_ready),
    .ram_read_data (ram_read_data),
    .core_cs       (core_cs),
    .core_ready    (core_ready),
    .core_read_data(core_read_data),
    .direct_ack    (direct_ack),
    .ready         (ready),
    .rdata         (rdata)
  );

endmodule

`default_nettype wire

/* hdl/mmio_core.sv */
`timescale 1ns/1ns
`default_nettype none

module mmio_core #(
  parameter int CORE_ID = 0
) (
  input  wire                                 clk,
  input  wire                                 reset_n,

  input  wire                                 cs,
  input  wire                                 we,
  input  wire [soc_pkg::core_regs_log2-1:0]   address,
  input  soc_pkg::word_t                      write_data,
  output soc_pkg::word_t                      read_data,
  output logic                                ready
);

  localparam int num_regs = 1 << soc_pkg::core_regs_log2;

  // Fixed identity word for register 0
  localparam soc_pkg::word_t id_word = soc_pkg::core_id_base + soc_pkg::word_t'(CORE_ID);

  soc_pkg::word_t scratch [1:num_regs-1];

  //----------------------------------------
  // Scratch registers and ready
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready <= 1'b0;
      for (int i = 1; i < num_regs; i++) begin
        scratch[i] <= '0;
      end
    end
    else begin
      ready <= cs;
      // Register 0 is read only
      if (cs && we && address != '0) begin
        scratch[address] <= write_data;
      end
    end
  end

  //----------------------------------------
  // Read path
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (cs) begin
      if (address == '0) begin
        read_data <= id_word;
      end
      else begin
        read_data <= scratch[address];
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/ram.sv */
`timescale 1ns/1ns
`default_nettype none

module ram (
  input  wire                                 clk,
  input  wire                                 reset_n,

  input  wire                                 cs,
  input  wire [3:0]                           we,
  input  wire [soc_pkg::ram_words_log2-1:0]   address,
  input  soc_pkg::word_t                      write_data,
  output soc_pkg::word_t                      read_data,
  output logic                                ready
);

  localparam int depth = 1 << soc_pkg::ram_words_log2;

  soc_pkg::word_t mem [0:depth-1];

  //----------------------------------------
  // Storage with byte lanes
  //----------------------------------------
  always_ff @(posedge clk) begin
    for (int lane = 0; lane < 4; lane++) begin
      if (cs && we[lane]) begin
        mem[address][lane*8 +: 8] <= write_data[lane*8 +: 8];
      end
    end
  end

  // Old contents on a write cycle, master ignores it
  always_ff @(posedge clk) begin
    if (cs) begin
      read_data <= mem[address];
    end
  end

  //----------------------------------------
  // Ready one cycle after select
  //----------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready <= 1'b0;
    end
    else begin
      ready <= cs;
    end
  end

endmodule

`default_nettype wire

/* hdl/rdata_mux.sv */
`timescale 1ns/1ns
`default_nettype none

module rdata_mux #(
  parameter int NUM_CORES = 4
) (
  input  wire                                 clk,
  input  wire                                 reset_n,

  input  wire                                 ram_cs,
  input  wire                                 ram_ready,
  input  soc_pkg::word_t                      ram_read_data,
  input  wire [NUM_CORES-1:0]                 core_cs,
  input  wire [NUM_CORES-1:0]                 core_ready,
  input  soc_pkg::word_t [NUM_CORES-1:0]      core_read_data,
  input  wire                                 direct_ack,

  output logic                                ready,
  output soc_pkg::word_t                      rdata
);

  logic           ready_new;
  soc_pkg::word_t rdata_new;

  //----------------------------------------
  // Pick the selected responder
  //----------------------------------------
  always_comb begin
    ready_new = 1'b0;
    rdata_new = '0;

    // Reserved or absent target answers zero at once
    if (direct_ack) begin
      ready_new = 1'b1;
    end
    else if (ram_cs) begin
      ready_new = ram_ready;
      rdata_new = ram_read_data;
    end
    else begin
      for (int i = 0; i < NUM_CORES; i++) begin
        if (core_cs[i]) begin
          ready_new = core_ready[i];
          rdata_new = core_read_data[i];
        end
      end
    end
  end

  // Bus side registers
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ready <= 1'b0;
      rdata <= '0;
    end
    else begin
      ready <= ready_new;
      rdata <= rdata_new;
    end
  end

endmodule

`default_nettype wire

/* hdl/soc_pkg.sv */
`default_nettype none

package soc_pkg;

  //----------------------------------------
  // Bus word and area codes
  //----------------------------------------
  typedef logic [31:0] word_t;

  // Top level area in address bits 31:30
  // Code 2 has no name and decodes as reserved
  typedef enum logic [1:0] {
    area_reserved = 2'd0,
    area_ram      = 2'd1,
    area_mmio     = 2'd3
  } area_t;

  //----------------------------------------
  // Address field positions
  //----------------------------------------
  localparam int area_msb = 31;
  localparam int area_lsb = 30;
  localparam int core_msb = 29;
  localparam int core_lsb = 24;

  // Word index widths, both start at bit 2
  localparam int ram_words_log2 = 8;
  localparam int core_regs_log2 = 3;

  // Identity register base, core index added per core
  localparam word_t core_id_base = 32'hc0de0000;

endpackage

`default_nettype wire

/* test/bus_fabric_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_fabric_asserts #(
  parameter int NUM_CORES = 4
) (
  input wire                 clk,
  input wire                 reset_n,
  input wire                 valid,
  input wire                 ready,
  input wire                 ram_cs,
  input wire [NUM_CORES-1:0] core_cs,
  input wire                 direct_ack
);

  // Sticky failure flags
  logic pulse_err  = 1'b0;
  logic rise_err   = 1'b0;
  logic select_err = 1'b0;
  logic reset_err  = 1'b0;
  logic failed;

  assign failed = pulse_err | rise_err | select_err | reset_err;

  //----------------------------------------
  // Bus handshake
  //----------------------------------------
  ready_pulse: assert property (@(posedge clk) disable iff (!reset_n) ready |=> !ready)
    else begin
      pulse_err = 1'b1;
      $error("ready high for two cycles in a row");
    end

  // A transfer must have been pending before its ready
  ready_after_valid: assert property (
    @(posedge clk) disable iff (!reset_n) $rose(ready) |-> $past(valid))
    else begin
      rise_err = 1'b1;
      $error("ready rose without valid in the cycle before");
    end

  //----------------------------------------
  // Chip selects
  //----------------------------------------
  select_onehot: assert property (
    @(posedge clk) disable iff (!reset_n) $onehot0({ram_cs, core_cs, direct_ack}))
    else begin
      select_err = 1'b1;
      $error("more than one select high");
    end

  quiet_in_reset: assert property (
    @(posedge clk) (!reset_n && $past(!reset_n)) |->
      (!ready && !ram_cs && core_cs == '0 && !direct_ack))
    else begin
      reset_err = 1'b1;
      $error("ready or a select high during reset");
    end

endmodule

bind bus_fabric bus_fabric_asserts #(
  .NUM_CORES(NUM_CORES)
) asserts_inst (
  .clk       (clk),
  .reset_n   (reset_n),
  .valid     (valid),
  .ready     (ready),
  .ram_cs    (ram_cs),
  .core_cs   (core_cs),
  .direct_ack(direct_ack)
);

`default_nettype wire

/* test/bus_fabric_cases.txt */
# op addr wdata strb expected chain (all hex but chain)
# chain 1 starts the transfer in the cycle right after the previous ready
read  c1000004 00000000 0 00000000 0
read  c300001c 00000000 0 00000000 0
write 40000000 11223344 f 00000000 0
read  40000000 00000000 0 11223344 0
write 40000000 aabbccdd 1 00000000 0
write 40000000 eeff0000 c 00000000 0
read  40000000 00000000 0 eeff33dd 0
write 40000010 01020304 f 00000000 0
write 40000010 cafef00d 6 00000000 0
read  40000010 00000000 0 01fef004 0
read  c0000000 00000000 0 c0de0000 0
read  c1000000 00000000 0 c0de0001 0
write c2000000 ffffffff f 00000000 0
read  c2000000 00000000 0 c0de0002 0
write c0000008 12345678 f 00000000 0
write c1000008 9abcdef0 f 00000000 0
read  c0000008 00000000 0 12345678 0
read  c1000008 00000000 0 9abcdef0 0
read  c2000008 00000000 0 00000000 0
read  00000010 00000000 0 00000000 0
write 80000020 deadbeef f 00000000 0
read  c4000000 00000000 0 00000000 0
write ff00000c 55555555 3 00000000 0
write 400003fc 0badf00d f 00000000 0
read  400003fc 00000000 0 0badf00d 1
read  c0000008 00000000 0 12345678 1
read  00000000 00000000 0 00000000 1
read  c3000000 00000000 0 c0de0003 1

/* test/bus_fabric_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_fabric_tb;

  localparam int num_cores     = 4;
  localparam int ready_timeout = 10;

  logic           clk;
  logic           reset_n;
  logic           valid;
  soc_pkg::word_t addr;
  soc_pkg::word_t wdata;
  logic [3:0]     wstrb;
  logic           ready;
  soc_pkg::word_t rdata;

  bus_fabric #(
    .NUM_CORES(num_cores)
  ) DUT (
    .clk    (clk),
    .reset_n(reset_n),
    .valid  (valid),
    .addr   (addr),
    .wdata  (wdata),
    .wstrb  (wstrb),
    .ready  (ready),
    .rdata  (rdata)
  );

  always #20 clk = ~clk;

  //----------------------------------------
  // Failure handling and compare tasks
  //----------------------------------------
  task automatic abort_run();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input soc_pkg::word_t got,
                            input soc_pkg::word_t expected);
    if (got !== expected) begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, expected);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, expected);
      abort_run();
    end
  endtask

  task automatic check_latency(input string name, input int got, input int expected);
    if (got != expected) begin
      $display("mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, expected);
      abort_run();
    end
  endtask

  always @(negedge clk) begin
    if (DUT.asserts_inst.failed) begin
      $display("a bus protocol assertion failed");
      abort_run();
    end
  end

  // Reserved area or a core number past the last core
  function automatic logic direct_target(input soc_pkg::word_t a);
    soc_pkg::area_t area;
    area = soc_pkg::area_t'(a[soc_pkg::area_msb:soc_pkg::area_lsb]);
    if (area == soc_pkg::area_ram) return 1'b0;
    if (area == soc_pkg::area_mmio) begin
      return int'(a[soc_pkg::core_msb:soc_pkg::core_lsb]) >= num_cores;
    end
    return 1'b1;
  endfunction

  //----------------------------------------
  // Bus master
  //----------------------------------------
  task automatic wait_ready(output int cycles);
    int count;
    count = 0;
    @(negedge clk);
    while (!ready) begin
      count++;
      if (count >= ready_timeout) begin
        $display("no ready within %0d cycles for address %h", ready_timeout, addr);
        abort_run();
      end
      @(negedge clk);
    end
    cycles = count;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
      valid = 1'b0;
      wstrb = 4'h0;
    end
  endtask

  task automatic run_transfer(input soc_pkg::word_t a, input soc_pkg::word_t d,
                              input logic [3:0] s, input logic is_read,
                              input soc_pkg::word_t expected);
    int cycles;
    logic direct;
    direct = direct_target(a);
    @(posedge clk);
    #2;
    valid = 1'b1;
    addr  = a;
    wdata = d;
    wstrb = s;
    wait_ready(cycles);
    check_latency("ready latency", cycles, direct ? 1 : 2);
    if (is_read) begin
      check_word("rdata", rdata, expected);
    end
    else if (direct) begin
      check_word("rdata", rdata, '0);
    end
  endtask

  //----------------------------------------
  // Reset, then transfers from the case file
  //----------------------------------------
  initial begin : main
    int             fd;
    int             items;
    int             chained;
    int             count;
    string          line;
    string          op;
    soc_pkg::word_t a;
    soc_pkg::word_t d;
    soc_pkg::word_t expected;
    logic [3:0]     s;
    logic           is_read;

    clk     = 1'b0;
    reset_n = 1'b0;
    valid   = 1'b0;
    addr    = '0;
    wdata   = '0;
    wstrb   = 4'h0;
    count   = 0;
    void'($urandom(30));

    repeat (2) @(posedge clk);
    repeat (6) begin
      @(negedge clk);
      check_flag("ready", ready, 1'b0);
      check_word("rdata", rdata, '0);
    end
    @(posedge clk);
    #2;
    reset_n = 1'b1;

    fd = $fopen("test/bus_fabric_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open case file test/bus_fabric_cases.txt");
      abort_run();
    end

    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;
      items = $sscanf(line, "%s %h %h %h %h %d", op, a, d, s, expected, chained);
      is_read = (op == "read");
      if (items != 6 || (!is_read && op != "write") || is_read == (s != 4'h0)) begin
        $display("malformed line in case file: %s", line);
        abort_run();
      end
      // Random idle gap unless the line chains onto the previous transfer
      if (chained == 0) begin
        idle_cycles(int'($urandom % 4));
      end
      run_transfer(a, d, s, is_read, expected);
      count++;
    end
    $fclose(fd);
    idle_cycles(2);

    $display("%0d transfers checked", count);
    if (DUT.asserts_inst.failed) begin
      abort_run();
    end
    else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
